//--- src/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and instruction width
`define CPU_WORD       16

// Register file size
`define CPU_NREGS      8
`define CPU_REG_BITS   3

// Instruction memory, word addressed by pc[8:1]
`define CPU_IMEM_WORDS 256
`define CPU_IMEM_BITS  8

// Opcode field, instr[15:12]
`define CPU_OP_ALU     4'h0
`define CPU_OP_ADDI    4'h1
`define CPU_OP_LI      4'h2
`define CPU_OP_BEQZ    4'h4
`define CPU_OP_BNEZ    4'h5
`define CPU_OP_HALT    4'hf

`endif

//--- src/cpu_pkg.sv
`default_nettype none
`include "cpu_consts.svh"

package cpu_pkg;

   // Opcodes, anything not listed is illegal
   typedef enum logic [3:0] {
      OP_ALU  = `CPU_OP_ALU,
      OP_ADDI = `CPU_OP_ADDI,
      OP_LI   = `CPU_OP_LI,
      OP_BEQZ = `CPU_OP_BEQZ,
      OP_BNEZ = `CPU_OP_BNEZ,
      OP_HALT = `CPU_OP_HALT
   } opcode_t;

   // R-type function field, instr[2:0]
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLL = 3'd5,
      ALU_SRL = 3'd6,
      ALU_SRA = 3'd7
   } alu_fn_t;

   // Fetch to decode, just the raw word
   typedef struct packed {
      logic [`CPU_WORD-1:0] instr;
   } fetch_word_t;

   // Decode to execute
   typedef struct packed {
      alu_fn_t                  fn;
      logic [`CPU_REG_BITS-1:0] rd;
      logic                     reg_write;
      logic                     use_imm;   // B from imm, not op_b
      logic                     br_z;      // BEQZ
      logic                     br_nz;     // BNEZ
      logic [`CPU_WORD-1:0]     op_a;
      logic [`CPU_WORD-1:0]     op_b;
      logic [`CPU_WORD-1:0]     imm;       // Already sign-extended
   } decoded_t;

endpackage

`default_nettype wire

//--- src/pipe_if.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpu_consts.svh"

// One pipeline hop, payload type set per instance
interface pipe_if #(parameter type payload_t = logic);
   logic                 valid;    // Payload holds a live instruction
   logic [`CPU_WORD-1:0] pc;       // Byte address of that instruction
   payload_t             payload;
   logic                 kill;     // Back from downstream, one-cycle flush

   // Upstream side
   modport src (
      output valid,
      output pc,
      output payload,
      input  kill
   );

   // Downstream side
   modport dst (
      input  valid,
      input  pc,
      input  payload,
      output kill
   );
endinterface

`default_nettype wire

//--- src/alu.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu import cpu_pkg::*; (
   input  wire [`CPU_WORD-1:0]  a,
   input  wire [`CPU_WORD-1:0]  b,
   input  wire alu_fn_t         fn,
   output logic [`CPU_WORD-1:0] result,
   output logic                 ofl,     // Signed overflow, ADD and SUB only
   output logic                 zero
);

   logic [3:0] shamt;
   logic       sa;
   logic       sb;
   logic       sr;

   assign shamt = b[3:0];                 // Shift by low four bits
   assign sa    = a[`CPU_WORD-1];
   assign sb    = b[`CPU_WORD-1];
   assign sr    = result[`CPU_WORD-1];

   always_comb begin
      result = '0;
      case (fn)
         ALU_ADD: result = a + b;
         ALU_SUB: result = a - b;         // Wraps
         ALU_AND: result = a & b;
         ALU_OR:  result = a | b;
         ALU_XOR: result = a ^ b;
         ALU_SLL: result = a << shamt;
         ALU_SRL: result = a >> shamt;    // Zero fill
         ALU_SRA: result = $signed(a) >>> shamt; // Sign fill
         default: result = '0;
      endcase
   end

   // Overflow on sign mismatch
   always_comb begin
      case (fn)
         ALU_ADD: ofl = (sa == sb) && (sr != sa);
         ALU_SUB: ofl = (sa != sb) && (sr != sa);
         default: ofl = 1'b0;
      endcase
   end

   assign zero = (result == '0);

endmodule

`default_nettype wire

//--- src/reg_file.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpu_consts.svh"

module reg_file (
   input  wire                      clk,
   input  wire                      rst,
   input  wire [`CPU_REG_BITS-1:0]  read1regsel,
   input  wire [`CPU_REG_BITS-1:0]  read2regsel,
   input  wire [`CPU_REG_BITS-1:0]  writeregsel,
   input  wire [`CPU_WORD-1:0]      writedata,
   input  wire                      write,
   output logic [`CPU_WORD-1:0]     read1data,
   output logic [`CPU_WORD-1:0]     read2data
);

   logic [`CPU_WORD-1:0] regs [`CPU_NREGS];
   logic                 byp1;
   logic                 byp2;

   // Write port, everything cleared on reset
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `CPU_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (write) begin
         regs[writeregsel] <= writedata;
      end
   end

   // Same-cycle write hits the read
   assign byp1 = write && (read1regsel == writeregsel);
   assign byp2 = write && (read2regsel == writeregsel);

   // Write-through so decode sees what execute is retiring
   assign read1data = byp1 ? writedata : regs[read1regsel];
   assign read2data = byp2 ? writedata : regs[read2regsel];

endmodule

`default_nettype wire

//--- src/fetch_stage.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetch_stage import cpu_pkg::*; (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       run,         // Level, enables fetch
   input  wire                       load,        // Program write strobe
   input  wire [`CPU_IMEM_BITS-1:0]  load_addr,
   input  wire [`CPU_WORD-1:0]       load_data,
   input  wire                       redirect,    // Taken branch in execute
   input  wire [`CPU_WORD-1:0]       redirect_pc,
   input  wire                       halt_seen,   // HALT sitting in decode
   output logic                      halted,
   pipe_if.src                       out
);

   logic [`CPU_WORD-1:0] imem [`CPU_IMEM_WORDS]; // Instruction memory
   logic [`CPU_WORD-1:0] pc;
   logic                 fetch_en;

   // Stop as soon as decode sees HALT so nothing younger slips through
   assign fetch_en = run & ~halted & ~halt_seen;

   // Program load port
   always_ff @(posedge clk) begin
      if (load) begin
         imem[load_addr] <= load_data;
      end
   end

   // Control state
   always_ff @(posedge clk) begin
      if (rst) begin
         pc        <= '0;
         out.valid <= 1'b0;
         halted    <= 1'b0;
      end else begin
         if (redirect) begin
            pc <= redirect_pc;                 // Branch target wins
         end else if (fetch_en) begin
            pc <= pc + `CPU_WORD'd2;           // Next word
         end
         out.valid <= fetch_en & ~out.kill;    // Drop on kill
         if (halt_seen) begin
            halted <= 1'b1;                    // Sticky until reset
         end
      end
   end

   // Registered fetch word, one cycle after pc read
   always_ff @(posedge clk) begin
      if (fetch_en) begin
         out.payload.instr <= imem[pc[`CPU_IMEM_BITS:1]];
         out.pc            <= pc;
      end
   end

   // Program may only change while the core is stopped
   a_no_load_while_run: assert property (
      @(posedge clk) disable iff (rst) !(load && run)
   ) else $error("fetch_stage: load asserted while run is high");

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_stage import cpu_pkg::*; (
   input  wire                      clk,
   input  wire                      rst,
   pipe_if.dst                      in,          // From fetch
   pipe_if.src                      out,         // To execute
   input  wire                      write,       // Writeback from execute
   input  wire [`CPU_REG_BITS-1:0]  writeregsel,
   input  wire [`CPU_WORD-1:0]      writedata,
   output logic                     halt_seen,
   output logic                     err          // Sticky illegal opcode
);

   logic [`CPU_WORD-1:0]     instr;
   opcode_t                  op;
   logic                     is_branch;
   logic                     is_halt;
   logic                     legal;
   logic [`CPU_REG_BITS-1:0] rs1_sel;
   logic [`CPU_WORD-1:0]     rd1;
   logic [`CPU_WORD-1:0]     rd2;
   logic [`CPU_WORD-1:0]     imm6_sx;
   logic [`CPU_WORD-1:0]     imm9_sx;
   decoded_t                 dec;

   assign instr     = in.payload.instr;
   assign op        = opcode_t'(instr[15:12]);
   assign is_branch = (op == OP_BEQZ) || (op == OP_BNEZ);

   // Branches test the register in the rd slot
   assign rs1_sel = is_branch ? instr[11:9] : instr[8:6];

   // Sign-extended immediates
   assign imm6_sx = {{(`CPU_WORD-6){instr[5]}}, instr[5:0]};
   assign imm9_sx = {{(`CPU_WORD-9){instr[8]}}, instr[8:0]};

   reg_file reg_file_inst (
      .clk         (clk),
      .rst         (rst),
      .read1regsel (rs1_sel),
      .read2regsel (instr[5:3]),
      .writeregsel (writeregsel),
      .writedata   (writedata),
      .write       (write),
      .read1data   (rd1),
      .read2data   (rd2)
   );

   // Field decode
   always_comb begin
      dec       = '0;                      // fn defaults to ADD
      dec.rd    = instr[11:9];
      dec.op_a  = rd1;
      dec.op_b  = rd2;
      legal     = 1'b1;
      is_halt   = 1'b0;
      case (op)
         OP_ALU: begin
            dec.fn        = alu_fn_t'(instr[2:0]);
            dec.reg_write = 1'b1;
         end
         OP_ADDI: begin
            dec.reg_write = 1'b1;
            dec.use_imm   = 1'b1;
            dec.imm       = imm6_sx;
         end
         OP_LI: begin
            dec.reg_write = 1'b1;
            dec.use_imm   = 1'b1;
            dec.op_a      = '0;            // 0 + imm9
            dec.imm       = imm9_sx;
         end
         OP_BEQZ: begin
            dec.br_z = 1'b1;
            dec.imm  = imm9_sx;
         end
         OP_BNEZ: begin
            dec.br_nz = 1'b1;
            dec.imm   = imm9_sx;
         end
         OP_HALT: is_halt = 1'b1;          // Consumed here
         default: legal = 1'b0;
      endcase
   end

   // Kill from execute goes straight on to fetch
   assign in.kill = out.kill;

   // A killed HALT must not stop the core
   assign halt_seen = in.valid & is_halt & ~out.kill;

   always_ff @(posedge clk) begin
      if (rst) begin
         out.valid <= 1'b0;
         err       <= 1'b0;
      end else begin
         out.valid <= in.valid & legal & ~is_halt & ~out.kill;
         if (in.valid && !legal && !out.kill) begin
            err <= 1'b1;
         end
      end
   end

   // Payload, no reset
   always_ff @(posedge clk) begin
      out.payload <= dec;
      out.pc      <= in.pc;
   end

   // Once raised, err holds until reset
   a_err_sticky: assert property (
      @(posedge clk) disable iff (rst) err |=> err
   ) else $error("decode_stage: err dropped without reset");

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpu_consts.svh"

module execute_stage import cpu_pkg::*; (
   input  wire                       clk,
   input  wire                       rst,
   pipe_if.dst                       in,           // From decode
   output logic                      write,        // Register write strobe
   output logic [`CPU_REG_BITS-1:0]  writeregsel,
   output logic [`CPU_WORD-1:0]      writedata,
   output logic                      redirect,     // Taken branch
   output logic [`CPU_WORD-1:0]      redirect_pc
);

   decoded_t             d;
   logic                 is_branch;
   logic [`CPU_WORD-1:0] alu_b;
   logic [`CPU_WORD-1:0] alu_out;
   logic                 alu_ofl;
   logic                 alu_zero;
   logic                 taken;

   assign d         = in.payload;
   assign is_branch = d.br_z | d.br_nz;

   // Branches pass A through so zero tests the register
   assign alu_b = is_branch ? '0 : (d.use_imm ? d.imm : d.op_b);

   alu alu_inst (
      .a      (d.op_a),
      .b      (alu_b),
      .fn     (d.fn),
      .result (alu_out),
      .ofl    (alu_ofl),
      .zero   (alu_zero)
   );

   assign taken = in.valid & ((d.br_z & alu_zero) | (d.br_nz & ~alu_zero));

   // Redirect and flush the two younger instructions
   assign redirect    = taken;
   assign in.kill     = taken;
   assign redirect_pc = in.pc + `CPU_WORD'd2 + {d.imm[`CPU_WORD-2:0], 1'b0};

   // Writeback, retired in this cycle
   assign write       = in.valid & d.reg_write;
   assign writeregsel = d.rd;
   assign writedata   = alu_out;

   // Bubble after a redirect means no taken branch right behind it
   a_redirect_single: assert property (
      @(posedge clk) disable iff (rst) redirect |=> !redirect
   ) else $error("execute_stage: redirect high two cycles in a row");

   // Overflow wraps, just note when the program exercises it
   c_alu_ofl: cover property (
      @(posedge clk) disable iff (rst) write && alu_ofl
   );

endmodule

`default_nettype wire

//--- src/cpu_top.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top import cpu_pkg::*; (
   input  wire                       clk,
   input  wire                       rst,
   input  wire                       load,
   input  wire [`CPU_IMEM_BITS-1:0]  load_addr,
   input  wire [`CPU_WORD-1:0]       load_data,
   input  wire                       run,
   output logic                      wb_valid,
   output logic [`CPU_REG_BITS-1:0]  wb_reg,
   output logic [`CPU_WORD-1:0]      wb_data,
   output logic                      halted,
   output logic                      err
);

   logic                     write;
   logic [`CPU_REG_BITS-1:0] writeregsel;
   logic [`CPU_WORD-1:0]     writedata;
   logic                     redirect;
   logic [`CPU_WORD-1:0]     redirect_pc;
   logic                     halt_seen;

   pipe_if #(.payload_t(fetch_word_t)) f2d ();  // Fetch to decode
   pipe_if #(.payload_t(decoded_t))    d2e ();  // Decode to execute

   fetch_stage fetch_stage_inst (
      .clk         (clk),
      .rst         (rst),
      .run         (run),
      .load        (load),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .halt_seen   (halt_seen),
      .halted      (halted),
      .out         (f2d)
   );

   decode_stage decode_stage_inst (
      .clk         (clk),
      .rst         (rst),
      .in          (f2d),
      .out         (d2e),
      .write       (write),
      .writeregsel (writeregsel),
      .writedata   (writedata),
      .halt_seen   (halt_seen),
      .err         (err)
   );

   execute_stage execute_stage_inst (
      .clk         (clk),
      .rst         (rst),
      .in          (d2e),
      .write       (write),
      .writeregsel (writeregsel),
      .writedata   (writedata),
      .redirect    (redirect),
      .redirect_pc (redirect_pc)
   );

   // Retirement is the register write port
   assign wb_valid = write;
   assign wb_reg   = writeregsel;
   assign wb_data  = writedata;

endmodule

`default_nettype wire

//--- bench/cpu_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb;

   logic                       clk;
   logic                       rst;
   logic                       load;
   logic [`CPU_IMEM_BITS-1:0]  load_addr;
   logic [`CPU_WORD-1:0]       load_data;
   logic                       run;
   logic                       wb_valid;
   logic [`CPU_REG_BITS-1:0]   wb_reg;
   logic [`CPU_WORD-1:0]       wb_data;
   logic                       halted;
   logic                       err;

   // Program image and expected retirement stream
   logic [`CPU_IMEM_BITS-1:0]  prog_addr[$];
   logic [`CPU_WORD-1:0]       prog_data[$];
   byte                        exp_kind[$];   // W writeback, E err flag
   string                      exp_test[$];
   logic [`CPU_REG_BITS-1:0]   exp_reg[$];
   logic [`CPU_WORD-1:0]       exp_val[$];
   int                         errors;

   cpu_top cpu_top_inst (
      .clk       (clk),
      .rst       (rst),
      .load      (load),
      .load_addr (load_addr),
      .load_data (load_data),
      .run       (run),
      .wb_valid  (wb_valid),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data),
      .halted    (halted),
      .err       (err)
   );

   always #20 clk = ~clk;  // 40 ns period

   task automatic check_wb(input string test,
                           input logic [`CPU_REG_BITS-1:0] e_reg,
                           input logic [`CPU_WORD-1:0] e_data,
                           input logic [`CPU_REG_BITS-1:0] a_reg,
                           input logic [`CPU_WORD-1:0] a_data);
      if (a_reg !== e_reg) begin
         $display("ERR %s: wb_reg expected %0d actual %0d", test, e_reg, a_reg);
         errors++;
      end
      if (a_data !== e_data) begin
         $display("ERR %s: wb_data expected %h actual %h", test, e_data, a_data);
         errors++;
      end
   endtask

   task automatic check_flag(input string test, input string name,
                             input logic e_bit, input logic a_bit);
      if (a_bit !== e_bit) begin
         $display("ERR %s: %s expected %b actual %b", test, name, e_bit, a_bit);
         errors++;
      end
   endtask

   // Parse the vectors file into program and expectation queues
   task automatic read_vectors();
      int    fd;
      int    n;
      int    want;
      string line;
      string cur_test;
      string name;
      int    a;
      int    d;
      cur_test = "none";
      fd = $fopen("bench/cpu_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open bench/cpu_vectors.txt");
         errors++;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2) continue;
         n    = 0;
         want = 0;               // Fields a line of this kind must carry
         case (line[0])
            "L": begin
               want = 2;
               n    = $sscanf(line, "L %h %h", a, d);
               prog_addr.push_back(a[`CPU_IMEM_BITS-1:0]);
               prog_data.push_back(d[`CPU_WORD-1:0]);
            end
            "T": begin
               want = 1;
               n    = $sscanf(line, "T %s", name);
               cur_test = name;
            end
            "W", "E": begin
               if (line[0] == "W") begin
                  want = 2;
                  n    = $sscanf(line, "W %d %h", a, d);
               end else begin
                  want = 1;
                  n    = $sscanf(line, "E %d", d);
               end
               exp_kind.push_back(line[0]);
               exp_test.push_back(cur_test);
               exp_reg.push_back(a[`CPU_REG_BITS-1:0]);
               exp_val.push_back(d[`CPU_WORD-1:0]);
            end
            default: ;  // Comments and blank lines
         endcase
         if (n != want) begin
            $display("Malformed line in bench/cpu_vectors.txt: %s", line);
            errors++;
         end
      end
      $fclose(fd);
   endtask

   // Flag checks sitting ahead of the next writeback, then the writeback
   task automatic retire_one();
      string                test;
      logic [`CPU_WORD-1:0] val;
      while (exp_kind.size() > 0 && exp_kind[0] == "E") begin
         test = exp_test.pop_front();
         val  = exp_val.pop_front();
         check_flag(test, "err", val[0], err);
         void'(exp_kind.pop_front());
         void'(exp_reg.pop_front());
      end
      if (exp_kind.size() == 0) begin
         $display("Unexpected writeback r%0d = %h after the expected list ran out",
                  wb_reg, wb_data);
         errors++;
      end else begin
         check_flag(exp_test[0], "halted", 1'b0, halted);   // Nothing retires once halted
         check_wb(exp_test.pop_front(), exp_reg.pop_front(), exp_val.pop_front(),
                  wb_reg, wb_data);
         void'(exp_kind.pop_front());
      end
   endtask

   initial begin
      int cycles;
      int limit;
      int drain;
      errors = 0;
      clk = 1'b0;
      rst = 1'b1;
      load = 1'b0;
      load_addr = '0;
      load_data = '0;
      run = 1'b0;
      void'($urandom(32'h0e6125eb));
      read_vectors();
      repeat (16) @(posedge clk);
      rst <= 1'b0;

      // Program load with random idle gaps
      foreach (prog_addr[i]) begin
         repeat ($urandom_range(0, 2)) begin
            @(posedge clk);
            load <= 1'b0;
         end
         @(posedge clk);
         load      <= 1'b1;
         load_addr <= prog_addr[i];
         load_data <= prog_data[i];
      end
      @(posedge clk);
      load <= 1'b0;
      @(posedge clk);
      run <= 1'b1;

      // Sample on the falling edge, clear of input updates
      limit = 4 * prog_addr.size() + 200;
      cycles = 0;
      drain = 0;
      while (drain < 8 && cycles <= limit) begin
         @(negedge clk);
         cycles++;
         if (wb_valid) retire_one();
         if (halted) drain++;
      end

      if (cycles > limit) begin
         $display("Timeout after %0d cycles without halt", limit);
         errors++;
      end else begin
         while (exp_kind.size() > 0) begin
            if (exp_kind[0] == "E") begin
               check_flag(exp_test[0], "err", exp_val[0][0], err);
            end else begin
               $display("Missing writeback r%0d = %h in test %s at halt",
                        exp_reg[0], exp_val[0], exp_test[0]);
               errors++;
            end
            void'(exp_kind.pop_front());
            void'(exp_test.pop_front());
            void'(exp_reg.pop_front());
            void'(exp_val.pop_front());
         end
      end

      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/cpu_pkg.sv
src/pipe_if.sv
src/alu.sv
src/reg_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/cpu_top.sv
bench/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal -f sources.f --top-module cpu_tb
output=$(./obj_dir/Vcpu_tb)
echo "$output"
if echo "$output" | grep -qx "all tests passed"; then
   exit 0
else
   exit 1
fi

//--- bench/cpu_vectors.txt
# L word_addr instr | T test_name | W reg data (retire order) | E err
# All numbers hex except W register and E flag
T alu_ops
L 00 2264
L 01 2403
L 02 0650
L 03 0889
L 04 0A62
L 05 0A53
L 06 0C64
L 07 0C55
L 08 0F16
L 09 0F17
L 0a 1245
W 1 0064
W 2 0003
W 3 0067
W 4 ff9f
W 5 0004
W 5 0067
W 6 fffb
W 6 0320
W 7 1ff3
W 7 fff3
W 1 0069
T back_to_back
L 0b 1481
L 0c 0690
L 0d 06D8
L 0e 08D1
L 0f 0B1C
W 2 0004
W 3 0008
W 3 0010
W 4 000c
W 5 001c
T branches
L 10 2203
L 11 2400
L 12 1482
L 13 127F
L 14 53FD
L 15 2601
L 16 2802
L 17 4202
L 18 2A07
L 19 2C07
L 1a 4602
L 1b 2A09
L 1c 5005
L 1d 2C55
W 1 0003
W 2 0000
W 2 0002
W 1 0002
W 2 0004
W 1 0001
W 2 0006
W 1 0000
W 3 0001
W 4 0002
W 5 0009
W 6 0055
T li_imm
L 1e 23FF
L 1f 2500
L 20 16A0
L 21 187F
L 22 2AFF
W 1 ffff
W 2 ff00
W 3 fee0
W 4 fffe
W 5 00ff
T halt
L 23 2E01
L 24 5E02
L 25 2C03
L 26 2C04
E 0
W 7 0001
T illegal
L 27 3000
L 28 F000
E 1
